// ==== verilog/chroni_reg_pkg.sv ====
package chroni_reg_pkg;

   typedef logic [6:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   // register offsets inside the chip window
   localparam reg_addr_t REG_PAL_INDEX     = 7'h04;
   localparam reg_addr_t REG_PAL_VALUE     = 7'h05;
   localparam reg_addr_t REG_VRAM_ADDR_L   = 7'h06;
   localparam reg_addr_t REG_VRAM_ADDR_M   = 7'h07;
   localparam reg_addr_t REG_VRAM_ADDR_H   = 7'h08;
   localparam reg_addr_t REG_VRAM_DATA     = 7'h09;
   localparam reg_addr_t REG_VRAM_AUX_L    = 7'h0a;
   localparam reg_addr_t REG_VRAM_AUX_M    = 7'h0b;
   localparam reg_addr_t REG_VRAM_AUX_H    = 7'h0c;
   localparam reg_addr_t REG_VRAM_AUX_DATA = 7'h0d;
   localparam reg_addr_t REG_STATUS        = 7'h12;
   localparam reg_addr_t REG_SCANLINE_IRQ  = 7'h13;
   localparam reg_addr_t REG_VRAM_PAGE_L   = 7'h26;   // word-granular pointer access
   localparam reg_addr_t REG_VRAM_PAGE_H   = 7'h27;
   localparam reg_addr_t REG_AUX_PAGE_L    = 7'h28;
   localparam reg_addr_t REG_AUX_PAGE_H    = 7'h29;

   // status register bits
   localparam int STAT_IRQ_EN     = 2;
   localparam int STAT_SPRITES    = 3;
   localparam int STAT_ENABLE     = 4;
   localparam int STAT_SCAN_FIRED = 6;
   localparam int STAT_VBL_FIRED  = 7;

   localparam logic [8:0] CHIP_BASE = 9'h120;   // paddr[15:7]

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [15:0] paddr;
      reg_data_t   pwdata;
   } apb_req_t;

endpackage

// ==== verilog/chroni_video_pkg.sv ====
package chroni_video_pkg;

   typedef logic [16:0] vram_byte_addr_t;
   typedef logic [15:0] vram_word_addr_t;
   typedef logic [15:0] vram_word_t;
   typedef logic [1:0]  byte_en_t;   // bit 1 is the high byte

   typedef struct packed {
      logic            en;
      vram_word_addr_t addr;
      vram_word_t      data;
      byte_en_t        byte_en;
   } vram_wr_t;

   typedef logic [7:0]  pal_index_t;
   typedef logic [15:0] pal_color_t;

   // one palette register event from the bus
   typedef struct packed {
      logic       index_wr;
      logic       value_wr;
      logic [7:0] data;
   } pal_wr_t;

   typedef logic [7:0] scanline_t;

   typedef enum logic [1:0] {
      PAL_IDLE,
      PAL_LO,
      PAL_HI,
      PAL_WRITE
   } pal_state_t;

endpackage

// ==== verilog/vram_dp.sv ====
`timescale 1ns/1ps

module vram_dp #(
   parameter int VRAM_WORDS = 65536
) (
   input  logic                              sys_clk,
   input  chroni_video_pkg::vram_wr_t        vram_wr,
   input  chroni_video_pkg::vram_word_addr_t vid_addr,
   output chroni_video_pkg::vram_word_t      vid_word
);

   localparam int AW = $clog2(VRAM_WORDS);

   chroni_video_pkg::vram_word_t mem [VRAM_WORDS];

   // cpu side, byte lanes written separately
   always_ff @(posedge sys_clk) begin
      if (vram_wr.en) begin
         if (vram_wr.byte_en[0]) begin
            mem[vram_wr.addr[AW-1:0]][7:0] <= vram_wr.data[7:0];
         end
         if (vram_wr.byte_en[1]) begin
            mem[vram_wr.addr[AW-1:0]][15:8] <= vram_wr.data[15:8];
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      vid_word <= mem[vid_addr[AW-1:0]];   // renderer side
   end

endmodule

// ==== verilog/palette_loader.sv ====
`timescale 1ns/1ps

module palette_loader (
   input  logic                         sys_clk,
   input  logic                         reset_n,
   input  chroni_video_pkg::pal_wr_t    pal_wr,
   input  chroni_video_pkg::pal_index_t pal_rd_index,
   output chroni_video_pkg::pal_color_t pal_rd_color
);

   chroni_video_pkg::pal_state_t state;
   chroni_video_pkg::pal_index_t index;
   chroni_video_pkg::pal_color_t value;
   chroni_video_pkg::pal_color_t pal_mem [256];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state <= chroni_video_pkg::PAL_IDLE;
      end else if (pal_wr.index_wr) begin
         state <= chroni_video_pkg::PAL_LO;
      end else if (pal_wr.value_wr && state == chroni_video_pkg::PAL_LO) begin
         state <= chroni_video_pkg::PAL_HI;
      end else if (pal_wr.value_wr && state == chroni_video_pkg::PAL_HI) begin
         state <= chroni_video_pkg::PAL_WRITE;
      end else if (state == chroni_video_pkg::PAL_WRITE) begin
         state <= chroni_video_pkg::PAL_LO;   // ready for the next color
      end
   end

   always_ff @(posedge sys_clk) begin
      if (pal_wr.index_wr) begin
         index <= pal_wr.data;
      end else if (state == chroni_video_pkg::PAL_WRITE) begin
         pal_mem[index] <= value;
         index          <= index + 1'b1;   // colors stream in byte pairs
      end
      if (pal_wr.value_wr && state == chroni_video_pkg::PAL_LO) begin
         value[7:0] <= pal_wr.data;
      end
      if (pal_wr.value_wr && state == chroni_video_pkg::PAL_HI) begin
         value[15:8] <= pal_wr.data;
      end
   end

   // renderer read port
   always_ff @(posedge sys_clk) begin
      pal_rd_color <= pal_mem[pal_rd_index];
   end

endmodule

// ==== verilog/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing #(
   parameter int H_TOTAL  = 800,
   parameter int H_ACTIVE = 640,
   parameter int V_TOTAL  = 256,
   parameter int V_ACTIVE = 240
) (
   input  logic                        sys_clk,
   input  logic                        reset_n,
   output logic                        h_blank,
   output logic                        v_blank,
   output chroni_video_pkg::scanline_t scanline
);

   localparam int HW = $clog2(H_TOTAL);
   localparam int VW = $clog2(V_TOTAL);

   localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
   localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);

   logic [HW-1:0] pix_cnt;
   logic [VW-1:0] line_cnt;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         pix_cnt  <= '0;
         line_cnt <= '0;
      end else if (pix_cnt == H_LAST) begin
         pix_cnt  <= '0;
         line_cnt <= (line_cnt == V_LAST) ? '0 : line_cnt + 1'b1;   // frame wrap
      end else begin
         pix_cnt <= pix_cnt + 1'b1;
      end
   end

   assign h_blank  = pix_cnt >= HW'(H_ACTIVE);
   assign v_blank  = line_cnt >= VW'(V_ACTIVE);
   assign scanline = chroni_video_pkg::scanline_t'(line_cnt);

endmodule

// ==== verilog/chroni_regs.sv ====
`timescale 1ns/1ps

module chroni_regs (
   input  logic                        sys_clk,
   input  logic                        reset_n,
   input  chroni_reg_pkg::apb_req_t    apb_req,
   output chroni_reg_pkg::reg_data_t   prdata,
   output logic                        pready,
   output chroni_video_pkg::vram_wr_t  vram_wr,
   output chroni_video_pkg::pal_wr_t   pal_wr,
   input  logic                        h_blank,
   input  logic                        v_blank,
   input  chroni_video_pkg::scanline_t scanline,
   output logic                        irq
);

   chroni_reg_pkg::reg_addr_t             offset;
   chroni_reg_pkg::reg_data_t             wdata;
   chroni_reg_pkg::reg_data_t             status;
   logic                                  wr_acc;
   logic                                  rd_acc;
   chroni_video_pkg::vram_byte_addr_t     vram_ptr;
   chroni_video_pkg::vram_byte_addr_t     aux_ptr;
   logic                                  stat_enable;
   logic                                  stat_sprites;
   logic                                  stat_irq_en;
   chroni_video_pkg::scanline_t           scan_cmp;
   logic                                  scan_fired;
   logic                                  vbl_fired;
   logic                                  wr_en;
   chroni_video_pkg::vram_word_addr_t     wr_addr;
   chroni_video_pkg::byte_en_t            wr_be;
   chroni_video_pkg::vram_word_t          wr_data;

   assign wr_acc = apb_req.psel && apb_req.penable && apb_req.pwrite &&
                   apb_req.paddr[15:7] == chroni_reg_pkg::CHIP_BASE;
   assign rd_acc = apb_req.psel && apb_req.penable && !apb_req.pwrite &&
                   apb_req.paddr[15:7] == chroni_reg_pkg::CHIP_BASE;
   assign offset = apb_req.paddr[6:0];
   assign wdata  = apb_req.pwdata;
   assign pready = 1'b1;   // no wait states

   assign pal_wr  = '{index_wr: wr_acc && offset == chroni_reg_pkg::REG_PAL_INDEX,
                      value_wr: wr_acc && offset == chroni_reg_pkg::REG_PAL_VALUE,
                      data:     wdata};
   assign vram_wr = '{en: wr_en, addr: wr_addr, data: wr_data, byte_en: wr_be};

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         vram_ptr     <= '0;
         aux_ptr      <= '0;
         stat_enable  <= 1'b1;
         stat_sprites <= 1'b1;
         stat_irq_en  <= 1'b0;
         scan_cmp     <= '0;
         wr_en        <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         if (wr_acc) begin
            case (offset)
               chroni_reg_pkg::REG_VRAM_ADDR_L:   vram_ptr[7:0]  <= wdata;
               chroni_reg_pkg::REG_VRAM_ADDR_M:   vram_ptr[15:8] <= wdata;
               chroni_reg_pkg::REG_VRAM_ADDR_H:   vram_ptr[16]   <= wdata[0];
               chroni_reg_pkg::REG_VRAM_AUX_L:    aux_ptr[7:0]   <= wdata;
               chroni_reg_pkg::REG_VRAM_AUX_M:    aux_ptr[15:8]  <= wdata;
               chroni_reg_pkg::REG_VRAM_AUX_H:    aux_ptr[16]    <= wdata[0];
               chroni_reg_pkg::REG_VRAM_PAGE_L:   vram_ptr[8:0]  <= {wdata, 1'b0};
               chroni_reg_pkg::REG_VRAM_PAGE_H:   vram_ptr[16:9] <= wdata;
               chroni_reg_pkg::REG_AUX_PAGE_L:    aux_ptr[8:0]   <= {wdata, 1'b0};
               chroni_reg_pkg::REG_AUX_PAGE_H:    aux_ptr[16:9]  <= wdata;
               chroni_reg_pkg::REG_SCANLINE_IRQ:  scan_cmp       <= wdata;
               chroni_reg_pkg::REG_VRAM_DATA: begin
                  wr_en    <= 1'b1;
                  vram_ptr <= vram_ptr + 1'b1;   // auto-increment
               end
               chroni_reg_pkg::REG_VRAM_AUX_DATA: begin
                  wr_en   <= 1'b1;
                  aux_ptr <= aux_ptr + 1'b1;
               end
               chroni_reg_pkg::REG_STATUS: begin
                  stat_enable  <= wdata[chroni_reg_pkg::STAT_ENABLE];
                  stat_sprites <= wdata[chroni_reg_pkg::STAT_SPRITES];
                  stat_irq_en  <= wdata[chroni_reg_pkg::STAT_IRQ_EN];
               end
               default: ;
            endcase
         end
      end
   end

   // write payload, sampled with the pointer value before the increment
   always_ff @(posedge sys_clk) begin
      wr_data <= {wdata, wdata};
      if (offset == chroni_reg_pkg::REG_VRAM_AUX_DATA) begin
         wr_addr <= aux_ptr[16:1];
         wr_be   <= aux_ptr[0] ? 2'b10 : 2'b11;   // even address fills the whole word
      end else begin
         wr_addr <= vram_ptr[16:1];
         wr_be   <= vram_ptr[0] ? 2'b10 : 2'b01;
      end
   end

   // fired flags are sticky until the next status write
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         scan_fired <= 1'b0;
         vbl_fired  <= 1'b0;
      end else begin
         scan_fired <= (scan_fired && !(wr_acc && offset == chroni_reg_pkg::REG_STATUS)) ||
                       (h_blank && chroni_video_pkg::scanline_t'(scanline + 1'b1) == scan_cmp);
         vbl_fired  <= (vbl_fired && !(wr_acc && offset == chroni_reg_pkg::REG_STATUS)) ||
                       v_blank;
      end
   end

   assign irq = stat_irq_en && (scan_fired || vbl_fired);

   always_comb begin
      status = '0;
      status[chroni_reg_pkg::STAT_VBL_FIRED]  = vbl_fired;
      status[chroni_reg_pkg::STAT_SCAN_FIRED] = scan_fired;
      status[chroni_reg_pkg::STAT_ENABLE]     = stat_enable;
      status[chroni_reg_pkg::STAT_SPRITES]    = stat_sprites;
      status[chroni_reg_pkg::STAT_IRQ_EN]     = stat_irq_en;
   end

   always_comb begin
      prdata = '0;
      if (rd_acc) begin
         case (offset)
            chroni_reg_pkg::REG_VRAM_ADDR_L:  prdata = vram_ptr[7:0];
            chroni_reg_pkg::REG_VRAM_ADDR_M:  prdata = vram_ptr[15:8];
            chroni_reg_pkg::REG_VRAM_ADDR_H:  prdata = {7'b0, vram_ptr[16]};
            chroni_reg_pkg::REG_VRAM_AUX_L:   prdata = aux_ptr[7:0];
            chroni_reg_pkg::REG_VRAM_AUX_M:   prdata = aux_ptr[15:8];
            chroni_reg_pkg::REG_VRAM_AUX_H:   prdata = {7'b0, aux_ptr[16]};
            chroni_reg_pkg::REG_VRAM_PAGE_L:  prdata = vram_ptr[8:1];
            chroni_reg_pkg::REG_VRAM_PAGE_H:  prdata = vram_ptr[16:9];
            chroni_reg_pkg::REG_AUX_PAGE_L:   prdata = aux_ptr[8:1];
            chroni_reg_pkg::REG_AUX_PAGE_H:   prdata = aux_ptr[16:9];
            chroni_reg_pkg::REG_STATUS:       prdata = status;
            chroni_reg_pkg::REG_SCANLINE_IRQ: prdata = scan_cmp;
            default:                          prdata = '0;
         endcase
      end
   end

endmodule

// ==== verilog/chroni_top.sv ====
`timescale 1ns/1ps

module chroni_top #(
   parameter int H_TOTAL    = 800,
   parameter int H_ACTIVE   = 640,
   parameter int V_TOTAL    = 256,
   parameter int V_ACTIVE   = 240,
   parameter int VRAM_WORDS = 65536
) (
   input  logic                              sys_clk,
   input  logic                              reset_n,
   input  chroni_reg_pkg::apb_req_t          apb_req,
   output chroni_reg_pkg::reg_data_t         prdata,
   output logic                              pready,
   output logic                              irq,
   input  chroni_video_pkg::vram_word_addr_t vid_addr,
   output chroni_video_pkg::vram_word_t      vid_word,
   input  chroni_video_pkg::pal_index_t      pal_rd_index,
   output chroni_video_pkg::pal_color_t      pal_rd_color
);

   chroni_video_pkg::vram_wr_t  vram_wr;
   chroni_video_pkg::pal_wr_t   pal_wr;
   chroni_video_pkg::scanline_t scanline;
   logic                        h_blank;
   logic                        v_blank;

   chroni_regs u_chroni_regs (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .apb_req  (apb_req),
      .prdata   (prdata),
      .pready   (pready),
      .vram_wr  (vram_wr),
      .pal_wr   (pal_wr),
      .h_blank  (h_blank),
      .v_blank  (v_blank),
      .scanline (scanline),
      .irq      (irq)
   );

   vram_dp #(
      .VRAM_WORDS (VRAM_WORDS)
   ) u_vram_dp (
      .sys_clk  (sys_clk),
      .vram_wr  (vram_wr),
      .vid_addr (vid_addr),
      .vid_word (vid_word)
   );

   palette_loader u_palette_loader (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .pal_wr       (pal_wr),
      .pal_rd_index (pal_rd_index),
      .pal_rd_color (pal_rd_color)
   );

   raster_timing #(
      .H_TOTAL  (H_TOTAL),
      .H_ACTIVE (H_ACTIVE),
      .V_TOTAL  (V_TOTAL),
      .V_ACTIVE (V_ACTIVE)
   ) u_raster_timing (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .h_blank  (h_blank),
      .v_blank  (v_blank),
      .scanline (scanline)
   );

endmodule

// ==== testbench/tb_chroni.sv ====
`timescale 1ns/1ps

module tb_chroni;

   localparam int H_TOTAL      = 16;
   localparam int H_ACTIVE     = 12;
   localparam int V_TOTAL      = 10;
   localparam int V_ACTIVE     = 8;
   localparam int VRAM_WORDS   = 1024;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

   localparam logic [2:0] OP_WR    = 3'd0;
   localparam logic [2:0] OP_RD    = 3'd1;   // masked compare
   localparam logic [2:0] OP_POLL  = 3'd2;   // read until the masked bits match
   localparam logic [2:0] OP_VPEEK = 3'd3;
   localparam logic [2:0] OP_PPEEK = 3'd4;
   localparam logic [2:0] OP_IRQ   = 3'd5;   // irq level, addr holds the wait in cycles

   localparam logic [15:0] ST_ON     = 16'((1 << chroni_reg_pkg::STAT_ENABLE) |
                                           (1 << chroni_reg_pkg::STAT_SPRITES));
   localparam logic [15:0] ST_IRQ_EN = 16'(1 << chroni_reg_pkg::STAT_IRQ_EN);
   localparam logic [15:0] ST_SCAN   = 16'(1 << chroni_reg_pkg::STAT_SCAN_FIRED);
   localparam logic [15:0] ST_VBL    = 16'(1 << chroni_reg_pkg::STAT_VBL_FIRED);

   typedef struct packed {
      logic [2:0]  op;
      logic [15:0] addr;
      logic [15:0] data;
      logic [15:0] mask;
   } step_t;

   logic                              sys_clk;
   logic                              reset_n;
   chroni_reg_pkg::apb_req_t          apb_req;
   chroni_reg_pkg::reg_data_t         prdata;
   logic                              pready;
   logic                              irq;
   chroni_video_pkg::vram_word_addr_t vid_addr;
   chroni_video_pkg::vram_word_t      vid_word;
   chroni_video_pkg::pal_index_t      pal_rd_index;
   chroni_video_pkg::pal_color_t      pal_rd_color;

   step_t       steps[$];
   string       names[$];
   logic [15:0] model_word [int];   // expected vram words
   logic [15:0] model_mask [int];   // lanes written so far
   logic [16:0] main_ptr;
   logic [16:0] aux_ptr;
   int          seed = 68638;
   bit          table_ready = 1'b0;

   chroni_top #(
      .H_TOTAL    (H_TOTAL),
      .H_ACTIVE   (H_ACTIVE),
      .V_TOTAL    (V_TOTAL),
      .V_ACTIVE   (V_ACTIVE),
      .VRAM_WORDS (VRAM_WORDS)
   ) u_chroni_top (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .apb_req      (apb_req),
      .prdata       (prdata),
      .pready       (pready),
      .irq          (irq),
      .vid_addr     (vid_addr),
      .vid_word     (vid_word),
      .pal_rd_index (pal_rd_index),
      .pal_rd_color (pal_rd_color)
   );

   initial begin
      sys_clk = 1'b0;
      forever #4 sys_clk = ~sys_clk;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected) begin
         stop_run($sformatf("Error %s: expected 0x%04h, actual 0x%04h", name, expected, actual));
      end
   endtask

   task automatic add_step(input logic [2:0] op, input logic [15:0] addr,
                           input logic [15:0] data, input logic [15:0] mask, input string name);
      steps.push_back('{op: op, addr: addr, data: data, mask: mask});
      names.push_back(name);
   endtask

   task automatic add_reg_step(input logic [2:0] op, input chroni_reg_pkg::reg_addr_t offset,
                               input logic [15:0] data, input logic [15:0] mask,
                               input string name);
      add_step(op, 16'(offset), data, mask, name);
   endtask

   task automatic set_pointer(input bit aux, input logic [16:0] value);
      chroni_reg_pkg::reg_addr_t base;
      base = aux ? chroni_reg_pkg::REG_VRAM_AUX_L : chroni_reg_pkg::REG_VRAM_ADDR_L;
      add_reg_step(OP_WR, base, {8'h00, value[7:0]}, 16'h00ff, "pointer low");
      add_reg_step(OP_WR, base + 7'd1, {8'h00, value[15:8]}, 16'h00ff, "pointer mid");
      add_reg_step(OP_WR, base + 7'd2, {15'h0000, value[16]}, 16'h00ff, "pointer high");
      if (aux) begin
         aux_ptr = value;
      end else begin
         main_ptr = value;
      end
   endtask

   // queues a data write and updates the expected memory image
   task automatic write_vram_byte(input bit aux, input logic [7:0] data);
      logic [16:0] baddr;
      logic [15:0] word;
      logic [15:0] mask;
      int          w;
      baddr = aux ? aux_ptr : main_ptr;
      w     = int'(baddr >> 1);
      word  = model_word.exists(w) ? model_word[w] : 16'h0000;
      mask  = model_mask.exists(w) ? model_mask[w] : 16'h0000;
      if (baddr[0] || aux) begin   // odd byte, or an aux write filling both lanes
         word[15:8] = data;
         mask[15:8] = 8'hff;
      end
      if (!baddr[0]) begin
         word[7:0] = data;
         mask[7:0] = 8'hff;
      end
      model_word[w] = word;
      model_mask[w] = mask;
      if (aux) begin
         add_reg_step(OP_WR, chroni_reg_pkg::REG_VRAM_AUX_DATA, {8'h00, data}, 16'h00ff,
                      "aux data write");
         aux_ptr = aux_ptr + 1'b1;
      end else begin
         add_reg_step(OP_WR, chroni_reg_pkg::REG_VRAM_DATA, {8'h00, data}, 16'h00ff,
                      "vram data write");
         main_ptr = main_ptr + 1'b1;
      end
   endtask

   task automatic add_vram_checks(input string name);
      foreach (model_word[w]) begin
         add_step(OP_VPEEK, 16'(w), model_word[w], model_mask[w],
                  $sformatf("%s 0x%03h", name, w));
      end
      model_word.delete();
      model_mask.delete();
   endtask

   task automatic build_table();
      logic [15:0] page;
      logic [15:0] colors [3];
      add_reg_step(OP_RD, chroni_reg_pkg::REG_STATUS, ST_ON, 16'h00ff, "status after reset");
      add_step(OP_IRQ, 16'h0000, 16'h0000, 16'h0001, "irq after reset");

      set_pointer(1'b0, 17'h00201);   // odd start, first byte lands in the high lane
      for (int i = 0; i < 4; i++) begin
         write_vram_byte(1'b0, 8'($random(seed)));
      end
      add_vram_checks("main port word");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_VRAM_ADDR_L, {8'h00, main_ptr[7:0]}, 16'h00ff,
                   "main pointer low");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_VRAM_ADDR_M, {8'h00, main_ptr[15:8]}, 16'h00ff,
                   "main pointer mid");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_VRAM_ADDR_H, {15'h0000, main_ptr[16]}, 16'h00ff,
                   "main pointer high");

      add_reg_step(OP_WR, chroni_reg_pkg::REG_AUX_PAGE_L, 16'h0040, 16'h00ff, "aux page low");
      add_reg_step(OP_WR, chroni_reg_pkg::REG_AUX_PAGE_H, 16'h0001, 16'h00ff, "aux page high");
      aux_ptr = {8'h01, 8'h40, 1'b0};   // page registers hold a word address
      write_vram_byte(1'b1, 8'($random(seed)));
      write_vram_byte(1'b1, 8'($random(seed)));
      set_pointer(1'b1, 17'h00305);
      write_vram_byte(1'b1, 8'($random(seed)));
      write_vram_byte(1'b1, 8'($random(seed)));
      add_vram_checks("aux port word");
      page = 16'(aux_ptr >> 1);
      add_reg_step(OP_RD, chroni_reg_pkg::REG_AUX_PAGE_L, {8'h00, page[7:0]}, 16'h00ff,
                   "aux page readback low");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_AUX_PAGE_H, {8'h00, page[15:8]}, 16'h00ff,
                   "aux page readback high");
      page = 16'(main_ptr >> 1);
      add_reg_step(OP_RD, chroni_reg_pkg::REG_VRAM_PAGE_L, {8'h00, page[7:0]}, 16'h00ff,
                   "main page readback low");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_VRAM_PAGE_H, {8'h00, page[15:8]}, 16'h00ff,
                   "main page readback high");

      colors[0] = 16'h1234;
      colors[1] = 16'habcd;
      colors[2] = 16'h0f0f;
      add_reg_step(OP_WR, chroni_reg_pkg::REG_PAL_INDEX, 16'h0020, 16'h00ff, "palette index");
      for (int i = 0; i < 3; i++) begin
         add_reg_step(OP_WR, chroni_reg_pkg::REG_PAL_VALUE, {8'h00, colors[i][7:0]}, 16'h00ff,
                      "palette low byte");
         add_reg_step(OP_WR, chroni_reg_pkg::REG_PAL_VALUE, {8'h00, colors[i][15:8]}, 16'h00ff,
                      "palette high byte");
      end
      for (int i = 0; i < 3; i++) begin
         add_step(OP_PPEEK, 16'(32 + i), colors[i], 16'hffff, $sformatf("palette entry %0d", 32 + i));
      end

      add_reg_step(OP_WR, chroni_reg_pkg::REG_STATUS, ST_ON | ST_IRQ_EN, 16'h00ff, "irq enable");
      add_step(OP_IRQ, 16'(2 * FRAME_CYCLES), 16'h0001, 16'h0001, "irq on vertical blank");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_STATUS, ST_ON | ST_IRQ_EN | ST_VBL, 16'h00ff,
                   "status with vbl fired");

      // a line 0 match lets the flags be cleared outside vertical blank
      add_reg_step(OP_WR, chroni_reg_pkg::REG_SCANLINE_IRQ, 16'h0001, 16'h00ff,
                   "first scanline compare");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_SCANLINE_IRQ, 16'h0001, 16'h00ff,
                   "scanline compare readback");
      add_reg_step(OP_POLL, chroni_reg_pkg::REG_STATUS, ST_SCAN, ST_SCAN, "scanline fired line 0");
      add_reg_step(OP_WR, chroni_reg_pkg::REG_SCANLINE_IRQ, 16'h0003, 16'h00ff, "scanline compare");
      add_reg_step(OP_WR, chroni_reg_pkg::REG_STATUS, ST_ON | ST_IRQ_EN, 16'h00ff, "clear flags");
      add_reg_step(OP_RD, chroni_reg_pkg::REG_STATUS, ST_ON | ST_IRQ_EN, 16'h00ff,
                   "status after clear");
      add_reg_step(OP_POLL, chroni_reg_pkg::REG_STATUS, ST_SCAN, ST_SCAN | ST_VBL,
                   "scanline fired");
      add_step(OP_IRQ, 16'h0000, 16'h0001, 16'h0001, "irq on scanline");
      add_reg_step(OP_WR, chroni_reg_pkg::REG_STATUS, ST_ON, 16'h00ff, "irq disable");
      add_step(OP_IRQ, 16'h0000, 16'h0000, 16'h0001, "irq after disable");
   endtask

   task automatic apb_write(input chroni_reg_pkg::reg_addr_t offset, input logic [7:0] data);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1,
                  paddr: {chroni_reg_pkg::CHIP_BASE, offset}, pwdata: data};
      @(posedge sys_clk);
      #1;
      apb_req.penable = 1'b1;
      @(posedge sys_clk);   // access edge
      #1;
      apb_req = '0;
   endtask

   task automatic apb_read(input chroni_reg_pkg::reg_addr_t offset, output logic [7:0] data);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0,
                  paddr: {chroni_reg_pkg::CHIP_BASE, offset}, pwdata: 8'h00};
      @(posedge sys_clk);
      #1;
      apb_req.penable = 1'b1;
      #2;
      data = prdata;   // mid access phase
      check_value("pready", 16'h0001, {15'h0000, pready});
      @(posedge sys_clk);
      #1;
      apb_req = '0;
   endtask

   task automatic run_step(input step_t s, input string name);
      logic [7:0] rd;
      int         tries;
      tries = 0;
      case (s.op)
         OP_WR: apb_write(s.addr[6:0], s.data[7:0]);
         OP_RD: begin
            apb_read(s.addr[6:0], rd);
            check_value(name, s.data & s.mask, {8'h00, rd} & s.mask);
         end
         OP_POLL: begin
            apb_read(s.addr[6:0], rd);
            while ((({8'h00, rd} ^ s.data) & s.mask) != 16'h0000 && tries < FRAME_CYCLES) begin
               apb_read(s.addr[6:0], rd);
               tries++;
            end
            check_value(name, s.data & s.mask, {8'h00, rd} & s.mask);
         end
         OP_VPEEK: begin
            vid_addr = s.addr;
            repeat (2) @(posedge sys_clk);   // pending write, then registered read
            #1;
            check_value(name, s.data & s.mask, vid_word & s.mask);
         end
         OP_PPEEK: begin
            pal_rd_index = s.addr[7:0];
            repeat (2) @(posedge sys_clk);
            #1;
            check_value(name, s.data & s.mask, pal_rd_color & s.mask);
         end
         OP_IRQ: begin
            while (irq !== s.data[0] && tries < int'(s.addr)) begin
               @(posedge sys_clk);
               #1;
               tries++;
            end
            if (irq !== s.data[0]) begin
               stop_run($sformatf("irq did not reach level %0d within %0d cycles at step %s",
                                  s.data[0], s.addr, name));
            end
         end
         default: stop_run("the stimulus table holds an unknown operation");
      endcase
   endtask

   initial begin
      int limit;
      wait (table_ready);
      limit = steps.size() * 20 + 2 * FRAME_CYCLES;
      repeat (limit) @(posedge sys_clk);
      stop_run("watchdog expired before the stimulus table finished");
   end

   initial begin
      reset_n      = 1'b0;
      apb_req      = '0;
      vid_addr     = '0;
      pal_rd_index = '0;
      main_ptr     = '0;
      aux_ptr      = '0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge sys_clk);
      #1;
      reset_n = 1'b1;
      for (int i = 0; i < steps.size(); i++) begin
         run_step(steps[i], names[i]);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== chroni.f ====
verilog/chroni_reg_pkg.sv
verilog/chroni_video_pkg.sv
verilog/vram_dp.sv
verilog/palette_loader.sv
verilog/raster_timing.sv
verilog/chroni_regs.sv
verilog/chroni_top.sv
testbench/tb_chroni.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the chroni testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_chroni -o sim_chroni -f chroni.f; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_chroni 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
   exit 0
fi
exit 1
